// File: src/chip_bus_pkg.sv
`default_nettype none

package chip_bus_pkg;

	// Byte address of the 68000 bus, bit 0 is never used for word accesses
	typedef logic [23:0] cpu_addr_t;

	// One 16-bit word as it travels on the data bus
	typedef logic [15:0] cpu_data_t;

	// Upper address bits 23:8 of the custom chip window at $B800xx
	localparam logic [15:0] akiko_base = 16'hB800;

	// Upper address bits 23:16 of the IDE task file window at $DAxxxx
	localparam logic [7:0] ide_base = 8'hDA;

	// Upper address bits 23:12 of the Gayle interrupt window at $DE1xxx
	localparam logic [11:0] gayle_base = 12'hDE1;

	// Identification word returned at offset 0 of the custom chip
	localparam logic [15:0] chip_id = 16'hCAFE;

endpackage

`default_nettype wire

// File: src/ide_pkg.sv
`default_nettype none

package ide_pkg;

	// Register index on the drive host port, 0 to 7 task file and 8 data
	typedef logic [3:0] ide_addr_t;

	// One byte of the ATA task file
	typedef logic [7:0] task_reg_t;

	// Request vector toward the drive host firmware
	typedef logic [2:0] ide_req_t;

	// Word count of a sector FIFO, one bit wider than the pointers
	typedef logic [8:0] fifo_level_t;

	// Positions inside ide_req_t
	localparam int req_cmd = 0;
	localparam int req_wsector = 1;
	localparam int req_rdata = 2;

	// One sector of 512 bytes held as 16-bit words
	localparam int sector_words = 256;
	localparam int fifo_ptr_w = $clog2(sector_words);

	// Task file indices as seen from the CPU through address bits 4:2
	localparam logic [2:0] reg_data = 3'd0;
	localparam logic [2:0] reg_cmd_status = 3'd7;

	// The host port reaches the sector data here
	localparam ide_addr_t host_data_idx = 4'd8;

	// Interrupt flag position in the Gayle status and enable bytes
	localparam int irq_bit = 7;

	// ATA READ SECTORS opcode
	localparam task_reg_t ata_read_cmd = 8'h20;

endpackage

`default_nettype wire

// File: src/sector_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sector_fifo
	import chip_bus_pkg::*;
	import ide_pkg::*;
(
	input  wire            clk_sys,
	input  wire            rst,
	input  wire            push,
	input  wire cpu_data_t din,
	input  wire            pop,
	output cpu_data_t      dout,
	output logic           empty,
	output logic           full,
	output fifo_level_t    level
);

	cpu_data_t mem [sector_words];

	// Pointers wrap by themselves since the depth is a power of two
	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic push_ok;
	logic pop_ok;

	assign push_ok = push & ~full;
	assign pop_ok = pop & ~empty;

	always_ff @(posedge clk_sys) begin
		if (push_ok) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// Head word is visible without a pop, one cycle after it was pushed
	assign dout = mem[rd_ptr];
	assign empty = level == '0;
	assign full = level == fifo_level_t'(sector_words);

	// Both consumers gate their pops on empty, so this catches a broken handshake
	assert property (@(posedge clk_sys) disable iff (rst) !(pop && empty))
		else $error("sector_fifo: pop while empty");

endmodule

`default_nettype wire

// File: src/id_regs.sv
`timescale 1ns/1ps
`default_nettype none

module id_regs
	import chip_bus_pkg::*;
(
	input  wire            clk_sys,
	input  wire            rst,
	input  wire            cs,
	input  wire            rd,
	input  wire            wr,
	input  wire            done,
	input  wire [4:0]      reg_addr,
	input  wire cpu_data_t din,
	output cpu_data_t      dout
);

	// Test-and-set flag, reads back at bit 15
	logic sem_flag;

	// Only completed accesses change state
	logic rd_done;
	logic wr_done;

	assign rd_done = cs & rd & done;
	assign wr_done = cs & wr & done;

	// First reader sees zero and owns the resource, later readers see it taken
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sem_flag <= 1'b0;
		end else if (wr_done && reg_addr == 5'd1) begin
			sem_flag <= 1'b0;
		end else if (rd_done && reg_addr == 5'd1) begin
			sem_flag <= 1'b1;
		end
	end

	always_comb begin
		dout = '0;
		if (cs && rd) begin
			case (reg_addr)
				5'd0: dout = chip_id;
				5'd1: dout = {sem_flag, 15'd0};
				default: dout = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/gayle_ide.sv
`timescale 1ns/1ps
`default_nettype none

module gayle_ide
	import chip_bus_pkg::*;
	import ide_pkg::*;
(
	input  wire              clk_sys,
	input  wire              rst,
	input  wire              ide_sel,
	input  wire              gayle_sel,
	input  wire              bus_rd,
	input  wire              bus_wr,
	input  wire              bus_done,
	input  wire [2:0]        reg_sel,
	input  wire              gayle_off,
	input  wire cpu_data_t   din,
	input  wire              uds,
	input  wire              wf_full,
	input  wire              wf_empty,
	input  wire fifo_level_t wf_level,
	input  wire cpu_data_t   wf_dout,
	input  wire              rf_empty,
	input  wire              rf_full,
	input  wire cpu_data_t   rf_dout,
	input  wire ide_addr_t   ide_address,
	input  wire              ide_write,
	input  wire              ide_read,
	input  wire cpu_data_t   ide_writedata,
	output cpu_data_t        dout,
	output logic             ide_nrdy,
	output logic             wf_push,
	output cpu_data_t        wf_din,
	output logic             wf_pop,
	output logic             rf_pop,
	output logic             rf_push,
	output cpu_data_t        rf_din,
	output logic             ide_irq,
	output ide_req_t         ide_req,
	output cpu_data_t        ide_readdata,
	output logic             ide_led
);

	// Task file bytes 1 to 6, shared by CPU and host
	task_reg_t task_file [1:6];
	task_reg_t cmd_reg;
	task_reg_t status_reg;
	task_reg_t gayle_byte;
	logic cmd_pending;
	logic irq_flag;
	logic irq_en;

	// Decoded access kinds
	logic cpu_wr;
	logic cpu_rd;
	logic data_sel;
	logic host_data;
	logic host_cmd;
	logic host_task;

	assign cpu_wr = bus_done & bus_wr;
	assign cpu_rd = bus_done & bus_rd;
	assign data_sel = ide_sel & (reg_sel == reg_data);
	assign host_data = ide_address == host_data_idx;
	assign host_cmd = ide_address == {1'b0, reg_cmd_status};
	assign host_task = (ide_address != '0) && (ide_address < {1'b0, reg_cmd_status});

	// Hold the CPU while the data port has nothing to give or no room to take
	assign ide_nrdy = data_sel & ((bus_rd & rf_empty) | (bus_wr & wf_full));

	// CPU side of the sector FIFOs, moving only on the completing edge
	assign wf_push = data_sel & cpu_wr;
	assign wf_din = din;
	assign rf_pop = data_sel & cpu_rd;

	// Host side, guarded so a stray strobe cannot corrupt the pointers
	assign wf_pop = ide_read & host_data & ~wf_empty;
	assign rf_push = ide_write & host_data & ~rf_full;
	assign rf_din = ide_writedata;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			for (int i = 1; i <= 6; i++) begin
				task_file[i] <= '0;
			end
			cmd_reg <= '0;
			status_reg <= '0;
			cmd_pending <= 1'b0;
			irq_flag <= 1'b0;
			irq_en <= 1'b0;
		end else begin
			// Gayle writes on the upper byte lane
			if (gayle_sel && cpu_wr && uds) begin
				if (gayle_off) begin
					irq_en <= din[8 + irq_bit];
				end else begin
					irq_flag <= 1'b0;
				end
			end
			// The host finishes a command by posting status
			if (ide_write && host_cmd) begin
				status_reg <= ide_writedata[7:0];
				cmd_pending <= 1'b0;
				if (irq_en) begin
					irq_flag <= 1'b1;
				end
			end else if (ide_write && host_task) begin
				task_file[ide_address[2:0]] <= ide_writedata[7:0];
			end
			// CPU writes come last so a new command is never lost
			if (ide_sel && cpu_wr && uds) begin
				if (reg_sel == reg_cmd_status) begin
					cmd_reg <= din[15:8];
					cmd_pending <= 1'b1;
				end else if (reg_sel != reg_data) begin
					task_file[reg_sel] <= din[15:8];
				end
			end
		end
	end

	// Offset 8 shows the enable, offset 0 the pending interrupt
	always_comb begin
		gayle_byte = '0;
		gayle_byte[irq_bit] = gayle_off ? irq_en : irq_flag;
	end

	always_comb begin
		dout = '0;
		if (ide_sel && bus_rd) begin
			case (reg_sel)
				reg_data: dout = rf_dout;
				reg_cmd_status: dout = {status_reg, 8'h00};
				default: dout = {task_file[reg_sel], 8'h00};
			endcase
		end else if (gayle_sel && bus_rd) begin
			dout = {gayle_byte, 8'h00};
		end
	end

	// Show-ahead FIFO output lets the host read data without a wait state
	always_comb begin
		ide_readdata = '0;
		if (host_data) begin
			ide_readdata = wf_dout;
		end else if (host_cmd) begin
			ide_readdata = {8'h00, cmd_reg};
		end else if (host_task) begin
			ide_readdata = {8'h00, task_file[ide_address[2:0]]};
		end
	end

	// Requests tell the firmware what the CPU is waiting for
	always_comb begin
		ide_req = '0;
		ide_req[req_cmd] = cmd_pending;
		ide_req[req_wsector] = wf_level == fifo_level_t'(sector_words);
		ide_req[req_rdata] = cmd_pending & (cmd_reg == ata_read_cmd) & rf_empty;
	end

	assign ide_irq = irq_flag;
	assign ide_led = cmd_pending;

	// The decoder must hold ready back while the write FIFO is full
	assert property (@(posedge clk_sys) disable iff (rst) !(wf_push && wf_full))
		else $error("gayle_ide: push into full write FIFO");

endmodule

`default_nettype wire

// File: src/fastchip.sv
`timescale 1ns/1ps
`default_nettype none

module fastchip
	import chip_bus_pkg::*;
(
	input  wire            clk_sys,
	input  wire            rst,
	input  wire            sel,
	input  wire            ide_ena,
	input  wire cpu_addr_t addr,
	input  wire            uds,
	input  wire            lds,
	input  wire            rnw,
	input  wire cpu_data_t akiko_dout,
	input  wire cpu_data_t ide_dout,
	input  wire            ide_nrdy,
	output logic           sel_ack,
	output logic           ready,
	output cpu_data_t      dout,
	output logic           akiko_cs,
	output logic           ide_sel,
	output logic           gayle_sel,
	output logic           bus_rd,
	output logic           bus_wr,
	output logic           bus_done
);

	// Set one cycle after an IDE or Gayle select, cleared after the access ends
	logic ide_ack;
	logic ide_ready;

	// The custom chip occupies one 256 byte page
	assign akiko_cs = sel & (addr[23:8] == akiko_base);

	// IDE and Gayle only answer when the drive is enabled, so the legacy
	// chip path keeps these addresses otherwise
	assign ide_sel = ide_ena & sel & (addr[23:16] == ide_base);
	assign gayle_sel = ide_ena & sel & (addr[23:12] == gayle_base);

	// Tells the master that some block on this path owns the address
	assign sel_ack = akiko_cs | ide_sel | gayle_sel;

	// A write needs at least one byte lane, a read takes the whole word
	assign bus_rd = sel & rnw;
	assign bus_wr = sel & ~rnw & (uds | lds);

	// The acknowledge register gives the IDE blocks their second cycle.
	// It drops on the completing edge so a held select cannot slip a
	// second access through with no wait cycle
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ide_ack <= 1'b0;
		end else begin
			ide_ack <= (ide_sel | gayle_sel) & ~bus_done;
		end
	end

	// Back-pressure from the FIFOs stretches the access
	assign ide_ready = ide_ack & (ide_sel | gayle_sel) & ~ide_nrdy;

	// The custom chip answers in the first cycle
	assign ready = akiko_cs | ide_ready;

	// The edge where the master samples ready and the access takes effect
	assign bus_done = sel_ack & ready;

	// Blocks return zero when not selected so OR is enough
	assign dout = akiko_dout | ide_dout;

	// Decode windows must never overlap
	assert property (@(posedge clk_sys) disable iff (rst)
		$onehot0({akiko_cs, ide_sel, gayle_sel}))
		else $error("fastchip: more than one block selected");

endmodule

`default_nettype wire

// File: src/fast_chip_top.sv
`timescale 1ns/1ps
`default_nettype none

module fast_chip_top
	import chip_bus_pkg::*;
	import ide_pkg::*;
(
	input  wire         clk_sys,
	input  wire         rst,
	input  wire         sel,
	input  wire         ide_ena,
	input  wire cpu_addr_t addr,
	input  wire cpu_data_t din,
	input  wire         uds,
	input  wire         lds,
	input  wire         rnw,
	input  wire ide_addr_t ide_address,
	input  wire         ide_write,
	input  wire         ide_read,
	input  wire cpu_data_t ide_writedata,
	output logic        sel_ack,
	output logic        ready,
	output cpu_data_t   dout,
	output logic        ide_irq,
	output ide_req_t    ide_req,
	output cpu_data_t   ide_readdata,
	output logic        ide_led
);

	// Decoder strobes shared by both register blocks
	logic akiko_cs;
	logic ide_sel;
	logic gayle_sel;
	logic bus_rd;
	logic bus_wr;
	logic bus_done;

	// Read words and wait request coming back from the blocks
	cpu_data_t akiko_dout;
	cpu_data_t ide_dout;
	logic ide_nrdy;

	// Write direction, CPU to drive host
	logic wf_push;
	logic wf_pop;
	cpu_data_t wf_din;
	cpu_data_t wf_dout;
	logic wf_empty;
	logic wf_full;
	fifo_level_t wf_level;

	// Read direction, drive host to CPU
	logic rf_push;
	logic rf_pop;
	cpu_data_t rf_din;
	cpu_data_t rf_dout;
	logic rf_empty;
	logic rf_full;

	fastchip decoder (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.sel        (sel),
		.ide_ena    (ide_ena),
		.addr       (addr),
		.uds        (uds),
		.lds        (lds),
		.rnw        (rnw),
		.akiko_dout (akiko_dout),
		.ide_dout   (ide_dout),
		.ide_nrdy   (ide_nrdy),
		.sel_ack    (sel_ack),
		.ready      (ready),
		.dout       (dout),
		.akiko_cs   (akiko_cs),
		.ide_sel    (ide_sel),
		.gayle_sel  (gayle_sel),
		.bus_rd     (bus_rd),
		.bus_wr     (bus_wr),
		.bus_done   (bus_done)
	);

	// Word offset within the $B800xx window
	id_regs ident (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.cs       (akiko_cs),
		.rd       (bus_rd),
		.wr       (bus_wr),
		.done     (bus_done),
		.reg_addr (addr[5:1]),
		.din      (din),
		.dout     (akiko_dout)
	);

	gayle_ide ide (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.ide_sel       (ide_sel),
		.gayle_sel     (gayle_sel),
		.bus_rd        (bus_rd),
		.bus_wr        (bus_wr),
		.bus_done      (bus_done),
		.reg_sel       (addr[4:2]),
		.gayle_off     (addr[3]),
		.din           (din),
		.uds           (uds),
		.wf_full       (wf_full),
		.wf_empty      (wf_empty),
		.wf_level      (wf_level),
		.wf_dout       (wf_dout),
		.rf_empty      (rf_empty),
		.rf_full       (rf_full),
		.rf_dout       (rf_dout),
		.ide_address   (ide_address),
		.ide_write     (ide_write),
		.ide_read      (ide_read),
		.ide_writedata (ide_writedata),
		.dout          (ide_dout),
		.ide_nrdy      (ide_nrdy),
		.wf_push       (wf_push),
		.wf_din        (wf_din),
		.wf_pop        (wf_pop),
		.rf_pop        (rf_pop),
		.rf_push       (rf_push),
		.rf_din        (rf_din),
		.ide_irq       (ide_irq),
		.ide_req       (ide_req),
		.ide_readdata  (ide_readdata),
		.ide_led       (ide_led)
	);

	sector_fifo wr_fifo (
		.clk_sys (clk_sys),
		.rst     (rst),
		.push    (wf_push),
		.din     (wf_din),
		.pop     (wf_pop),
		.dout    (wf_dout),
		.empty   (wf_empty),
		.full    (wf_full),
		.level   (wf_level)
	);

	// Nobody needs the fill count of the read direction
	sector_fifo rd_fifo (
		.clk_sys (clk_sys),
		.rst     (rst),
		.push    (rf_push),
		.din     (rf_din),
		.pop     (rf_pop),
		.dout    (rf_dout),
		.empty   (rf_empty),
		.full    (rf_full),
		.level   ()
	);

endmodule

`default_nettype wire

// File: tests/tb_drive_host.sv
`timescale 1ns/1ps
`default_nettype none

module tb_drive_host
	import chip_bus_pkg::*;
	import ide_pkg::*;
(
	input  wire            clk_sys,
	input  wire ide_req_t  ide_req,
	input  wire cpu_data_t ide_readdata,
	output ide_addr_t      ide_address,
	output logic           ide_write,
	output logic           ide_read,
	output cpu_data_t      ide_writedata
);

	// The port is idle until the firmware model is asked to act
	initial begin
		ide_address = '0;
		ide_write = 1'b0;
		ide_read = 1'b0;
		ide_writedata = '0;
	end

	// Single-cycle write strobe, taken by the DUT on the rising edge in between
	task automatic store_reg(input ide_addr_t idx, input cpu_data_t value);
		@(negedge clk_sys);
		ide_address = idx;
		ide_writedata = value;
		ide_write = 1'b1;
		@(negedge clk_sys);
		ide_write = 1'b0;
	endtask

	// Read data is combinational, so it is taken in the middle of the low phase
	// A data port read also pops the write FIFO on the following rising edge
	task automatic load_reg(input ide_addr_t idx, output cpu_data_t value);
		@(negedge clk_sys);
		ide_address = idx;
		ide_read = 1'b1;
		#5;
		value = ide_readdata;
		@(negedge clk_sys);
		ide_read = 1'b0;
	endtask

	// Poll one request bit the way the firmware loop does
	task automatic await_request(input int pos);
		@(negedge clk_sys);
		#5;
		while (!ide_req[pos]) begin
			@(negedge clk_sys);
			#5;
		end
	endtask

endmodule

`default_nettype wire

// File: tests/tb_fastchip.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fastchip
	import chip_bus_pkg::*;
	import ide_pkg::*;
();

	// Two sectors at about three cycles a word plus reset, setup and margin
	localparam int cycle_limit = 4000;

	// Cycles the host waits before it starts filling the read FIFO
	localparam int push_delay = 8;

	logic clk_sys;
	logic rst;
	logic sel;
	logic ide_ena;
	cpu_addr_t addr;
	cpu_data_t din;
	logic uds;
	logic lds;
	logic rnw;
	ide_addr_t ide_address;
	logic ide_write;
	logic ide_read;
	cpu_data_t ide_writedata;
	logic sel_ack;
	logic ready;
	cpu_data_t dout;
	logic ide_irq;
	ide_req_t ide_req;
	cpu_data_t ide_readdata;
	logic ide_led;

	int seed;
	int cycle_count;
	int checks_run;
	int value_errors;
	int ready_errors;

	fast_chip_top uut (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.sel           (sel),
		.ide_ena       (ide_ena),
		.addr          (addr),
		.din           (din),
		.uds           (uds),
		.lds           (lds),
		.rnw           (rnw),
		.ide_address   (ide_address),
		.ide_write     (ide_write),
		.ide_read      (ide_read),
		.ide_writedata (ide_writedata),
		.sel_ack       (sel_ack),
		.ready         (ready),
		.dout          (dout),
		.ide_irq       (ide_irq),
		.ide_req       (ide_req),
		.ide_readdata  (ide_readdata),
		.ide_led       (ide_led)
	);

	// Firmware side of the disk, owns the host port
	tb_drive_host host (
		.clk_sys       (clk_sys),
		.ide_req       (ide_req),
		.ide_readdata  (ide_readdata),
		.ide_address   (ide_address),
		.ide_write     (ide_write),
		.ide_read      (ide_read),
		.ide_writedata (ide_writedata)
	);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	// Ready must only come from a block that claimed the address
	assert property (@(posedge clk_sys) disable iff (rst) ready |-> sel_ack)
	else begin
		ready_errors++;
		$display("Ready was high on the CPU bus while no block acknowledged the address");
	end

	// Watchdog so a lost ready can never hang the run
	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
			$display("Errors: %0d value, %0d ready, %0d checks run",
				value_errors, ready_errors, checks_run);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic cpu_data_t random_word();
		int r;
		r = $random(seed);
		return r[15:0];
	endfunction

	task automatic compare_word(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks_run++;
		assert (actual === expected)
		else begin
			value_errors++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// One CPU access, held until ready is seen, then sel drops a cycle later
	// Ready is sampled in the middle of the low phase where it is stable
	task automatic bus_cycle(input cpu_addr_t a, input cpu_data_t wdata, input logic read,
		input logic upper, input logic lower, output cpu_data_t rdata, output int waits);
		@(negedge clk_sys);
		sel = 1'b1;
		addr = a;
		din = wdata;
		rnw = read;
		uds = upper;
		lds = lower;
		waits = 0;
		#5;
		while (!ready) begin
			@(negedge clk_sys);
			#5;
			waits++;
		end
		rdata = dout;
		@(negedge clk_sys);
		sel = 1'b0;
		rnw = 1'b1;
		uds = 1'b0;
		lds = 1'b0;
	endtask

	task automatic write_bus(input cpu_addr_t a, input cpu_data_t wdata,
		input logic upper, input logic lower);
		cpu_data_t unused_data;
		int unused_waits;
		bus_cycle(a, wdata, 1'b0, upper, lower, unused_data, unused_waits);
	endtask

	task automatic read_bus(input cpu_addr_t a, output cpu_data_t rdata, output int waits);
		bus_cycle(a, '0, 1'b1, 1'b1, 1'b1, rdata, waits);
	endtask

	// Select for one cycle only, the master gives up without waiting for ready
	task automatic probe_ack(input string name, input cpu_addr_t a, input logic hit);
		@(negedge clk_sys);
		sel = 1'b1;
		addr = a;
		rnw = 1'b1;
		uds = 1'b1;
		lds = 1'b1;
		#5;
		compare_word(name, 16'(hit), 16'(sel_ack));
		@(negedge clk_sys);
		sel = 1'b0;
	endtask

	task automatic decode_and_ident();
		cpu_data_t rdata;
		int waits;
		read_bus(24'hB80000, rdata, waits);
		compare_word("ident_word", 16'hCAFE, rdata);
		compare_word("ident_first_cycle", 16'd0, 16'(waits));
		// Test-and-set, the first reader gets zero and later readers see it taken
		read_bus(24'hB80002, rdata, waits);
		compare_word("sem_first", 16'h0000, rdata);
		read_bus(24'hB80002, rdata, waits);
		compare_word("sem_taken", 16'h8000, rdata);
		write_bus(24'hB80002, 16'h0000, 1'b1, 1'b1);
		read_bus(24'hB80002, rdata, waits);
		compare_word("sem_released", 16'h0000, rdata);
	endtask

	task automatic address_map();
		probe_ack("map_akiko", 24'hB80010, 1'b1);
		probe_ack("map_ide", 24'hDA0008, 1'b1);
		probe_ack("map_gayle", 24'hDE1000, 1'b1);
		probe_ack("map_gayle_gap", 24'hDE2000, 1'b0);
		probe_ack("map_akiko_gap", 24'hB90000, 1'b0);
		probe_ack("map_outside", 24'hC00000, 1'b0);
		// Without the drive enabled only the custom chip stays on this path
		@(negedge clk_sys);
		ide_ena = 1'b0;
		probe_ack("map_ide_disabled", 24'hDA0008, 1'b0);
		probe_ack("map_gayle_disabled", 24'hDE1000, 1'b0);
		probe_ack("map_akiko_kept", 24'hB80000, 1'b1);
		@(negedge clk_sys);
		ide_ena = 1'b1;
	endtask

	task automatic task_file_command();
		task_reg_t bytes [1:6];
		cpu_data_t word;
		cpu_data_t rdata;
		// Byte registers sit on the upper lane, one longword apart
		for (int i = 1; i <= 6; i++) begin
			word = random_word();
			bytes[i] = word[7:0];
			write_bus(24'hDA0000 + cpu_addr_t'(i * 4), {bytes[i], 8'h00}, 1'b1, 1'b0);
		end
		for (int i = 1; i <= 6; i++) begin
			host.load_reg(ide_addr_t'(i), rdata);
			compare_word($sformatf("task_reg_%0d", i), {8'h00, bytes[i]}, rdata);
		end
		// Write sectors command, left pending for the next test
		write_bus(24'hDA001C, {8'h30, 8'h00}, 1'b1, 1'b0);
		#5;
		compare_word("cmd_request", 16'd1, 16'(ide_req[req_cmd]));
		compare_word("cmd_led", 16'd1, 16'(ide_led));
		host.await_request(req_cmd);
		host.load_reg(4'd7, rdata);
		compare_word("cmd_readback", 16'h0030, rdata);
	endtask

	task automatic write_sector();
		cpu_data_t words [sector_words];
		cpu_data_t rdata;
		for (int i = 0; i < sector_words; i++) begin
			words[i] = random_word();
			write_bus(24'hDA0000, words[i], 1'b1, 1'b1);
		end
		#5;
		compare_word("wsector_request", 16'd1, 16'(ide_req[req_wsector]));
		// The host drains the sector in the order the CPU wrote it
		for (int i = 0; i < sector_words; i++) begin
			host.load_reg(4'd8, rdata);
			compare_word($sformatf("wsector_word_%0d", i), words[i], rdata);
		end
		#5;
		compare_word("wsector_drained", 16'd0, 16'(ide_req[req_wsector]));
		host.store_reg(4'd7, 16'h0050);
		#5;
		compare_word("wsector_cmd_done", 16'd0, 16'(ide_req[req_cmd]));
	endtask

	task automatic read_backpressure();
		cpu_data_t words [sector_words];
		cpu_data_t rdata;
		int waits;
		write_bus(24'hDA001C, {8'h20, 8'h00}, 1'b1, 1'b0);
		#5;
		compare_word("rdata_request", 16'd1, 16'(ide_req[req_rdata]));
		host.load_reg(4'd7, rdata);
		compare_word("rdata_cmd", 16'h0020, rdata);
		for (int i = 0; i < sector_words; i++) begin
			words[i] = random_word();
		end
		// The CPU read starts on an empty FIFO and must wait for the first push
		fork
			begin
				repeat (push_delay) @(negedge clk_sys);
				for (int i = 0; i < sector_words; i++) begin
					host.store_reg(4'd8, words[i]);
				end
			end
			begin
				for (int i = 0; i < sector_words; i++) begin
					read_bus(24'hDA0000, rdata, waits);
					compare_word($sformatf("rdata_word_%0d", i), words[i], rdata);
					if (i == 0) begin
						checks_run++;
						assert (waits >= push_delay + 1)
						else begin
							value_errors++;
							$display("Fail rdata_hold: expected at least %0d, actual %0d",
								push_delay + 1, waits);
						end
					end
				end
			end
		join
		host.store_reg(4'd7, 16'h0050);
		#5;
		compare_word("rdata_cmd_done", 16'd0, 16'(ide_req[req_cmd]));
	endtask

	task automatic interrupt_flow();
		cpu_data_t rdata;
		cpu_data_t irq_word;
		int waits;
		// Interrupt bit 7 of the Gayle byte lands on bit 15 of the bus word
		irq_word = 16'h0001 << (8 + irq_bit);
		write_bus(24'hDE1008, irq_word, 1'b1, 1'b0);
		read_bus(24'hDE1008, rdata, waits);
		compare_word("irq_enable_readback", irq_word, rdata);
		write_bus(24'hDA001C, {8'hEC, 8'h00}, 1'b1, 1'b0);
		host.await_request(req_cmd);
		host.store_reg(4'd7, 16'h0050);
		#5;
		compare_word("irq_raised", 16'd1, 16'(ide_irq));
		compare_word("irq_cmd_cleared", 16'd0, 16'(ide_req[req_cmd]));
		compare_word("irq_led_off", 16'd0, 16'(ide_led));
		read_bus(24'hDE1000, rdata, waits);
		compare_word("irq_status", irq_word, rdata);
		read_bus(24'hDA001C, rdata, waits);
		compare_word("irq_drive_status", 16'h5000, rdata);
		// Any write to offset 0 acknowledges the interrupt
		write_bus(24'hDE1000, 16'h0000, 1'b1, 1'b0);
		#5;
		compare_word("irq_cleared", 16'd0, 16'(ide_irq));
		// Same completion with the enable clear stays silent
		write_bus(24'hDE1008, 16'h0000, 1'b1, 1'b0);
		write_bus(24'hDA001C, {8'hEC, 8'h00}, 1'b1, 1'b0);
		host.await_request(req_cmd);
		host.store_reg(4'd7, 16'h0050);
		#5;
		compare_word("irq_disabled", 16'd0, 16'(ide_irq));
		compare_word("irq_disabled_led", 16'd0, 16'(ide_led));
	endtask

	initial begin
		seed = 32'hb395_b5f2;
		cycle_count = 0;
		checks_run = 0;
		value_errors = 0;
		ready_errors = 0;
		rst = 1'b1;
		sel = 1'b0;
		ide_ena = 1'b1;
		addr = '0;
		din = '0;
		uds = 1'b0;
		lds = 1'b0;
		rnw = 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rst = 1'b0;
		#5;
		// Everything quiet straight out of reset
		compare_word("reset_req", 16'd0, 16'(ide_req));
		compare_word("reset_irq", 16'd0, 16'(ide_irq));
		compare_word("reset_led", 16'd0, 16'(ide_led));
		compare_word("reset_ready", 16'd0, 16'(ready));
		decode_and_ident();
		address_map();
		task_file_command();
		write_sector();
		read_backpressure();
		interrupt_flow();
		repeat (2) @(negedge clk_sys);
		$display("Errors: %0d value, %0d ready, %0d checks run",
			value_errors, ready_errors, checks_run);
		if (value_errors == 0 && ready_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: fastchip_sub.f
src/chip_bus_pkg.sv
src/ide_pkg.sv
src/sector_fifo.sv
src/id_regs.sv
src/gayle_ide.sv
src/fastchip.sv
src/fast_chip_top.sv
tests/tb_drive_host.sv
tests/tb_fastchip.sv

// File: run_sim.sh
#!/bin/sh
set -e

# Build the testbench and the DUT into one simulation binary
verilator --binary --timing --assert -Wno-fatal --top-module tb_fastchip \
	-f fastchip_sub.f -o tb_fastchip_sim

# Run the simulation and keep its output
./obj_dir/tb_fastchip_sim > sim.log
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
